//--- hw/rp_pkg.sv
package rp_pkg;

    // Converter and arithmetic widths
    localparam int code_width   = 14;
    localparam int sample_width = 14;
    localparam int gain_width   = 16;
    localparam int frac_bits    = 13;                       // Gain of 8192 is unity
    localparam int prod_width   = sample_width + gain_width;
    localparam int sum_width    = prod_width - frac_bits + 1;

    typedef logic        [code_width-1:0]   adc_code_t;    // Offset binary from the ADC
    typedef logic signed [sample_width-1:0] sample_t;
    typedef logic        [code_width-1:0]   dac_code_t;    // Offset binary to the DAC
    typedef logic signed [gain_width-1:0]   gain_t;
    typedef logic signed [prod_width-1:0]   prod_t;
    typedef logic signed [sum_width-1:0]    sum_t;         // Shifted product plus offset

    localparam sample_t   sample_max = sample_t'(8191);
    localparam sample_t   sample_min = sample_t'(-8192);
    localparam dac_code_t dac_mid    = dac_code_t'(8192);  // Zero volts on the DAC

    typedef struct packed {
        adc_code_t ch_a;
        adc_code_t ch_b;
    } adc_pair_t;

    typedef struct packed {
        logic    valid;
        sample_t ch_a;
        sample_t ch_b;
    } sample_pair_t;

    typedef struct packed {
        dac_code_t ch_a;
        dac_code_t ch_b;
    } dac_pair_t;

    typedef struct packed {
        gain_t   gain;
        sample_t offset;
    } chan_cfg_t;

    typedef struct packed {
        chan_cfg_t cfg_a;
        chan_cfg_t cfg_b;
    } path_cfg_t;

    // Clocking
    localparam bit use_vendor_clocking = 1'b0;             // Pass-through clocks in this build
    localparam int lock_delay          = 16;
    localparam int lock_cnt_width      = $clog2(lock_delay + 1);
    localparam int rst_sync_stages     = 2;

endpackage

//--- hw/red_pitaya_infrastructure.sv
`timescale 1ns/1ps

module red_pitaya_infrastructure #(
    parameter int MULTIPLY = 8,   // User clock VCO multiplier
    parameter int DIVIDE   = 8,   // User clock output divider
    parameter int DIVCLK   = 1    // User clock input divider
) (
    input  logic adc_clk_in,
    input  logic rst_n,

    output logic usr_clk,
    output logic usr_rst,
    output logic adc_clk_125,
    output logic adc_rst,
    output logic dac_clk_250,
    output logic dac_rst,
    output logic dac_clk_250_315
);

    logic       lock_raw;   // Clocks stable and rst_n released
    logic [2:0] dom_clk;
    logic [2:0] dom_rst;

    logic [rp_pkg::lock_cnt_width-1:0] lock_cnt;

    // All domains share the input clock
    assign usr_clk         = adc_clk_in;
    assign adc_clk_125     = adc_clk_in;
    assign dac_clk_250     = adc_clk_in;
    assign dac_clk_250_315 = adc_clk_in;

    // Counter stands in for the generator lock time
    always_ff @(posedge adc_clk_in) begin
        if (!rst_n) begin
            lock_cnt <= '0;
        end else if (lock_cnt != rp_pkg::lock_cnt_width'(rp_pkg::lock_delay)) begin
            lock_cnt <= lock_cnt + 1'b1;
        end
    end

    assign lock_raw = rst_n & (lock_cnt == rp_pkg::lock_cnt_width'(rp_pkg::lock_delay));

    assign dom_clk = {dac_clk_250, adc_clk_125, usr_clk};

    // One synchronizer per domain, clocked by that domain's clock
    for (genvar d = 0; d < 3; d++) begin : g_rst_sync
        logic [rp_pkg::rst_sync_stages-1:0] sync_q;

        always_ff @(posedge dom_clk[d]) begin
            sync_q <= {sync_q[rp_pkg::rst_sync_stages-2:0], ~lock_raw};
        end

        assign dom_rst[d] = sync_q[rp_pkg::rst_sync_stages-1];
    end

    assign {dac_rst, adc_rst, usr_rst} = dom_rst;

endmodule

//--- hw/adc_capture.sv
`timescale 1ns/1ps

module adc_capture (
    input  logic                 adc_clk_125,
    input  logic                 adc_rst,
    input  rp_pkg::adc_pair_t    adc,
    output rp_pkg::sample_pair_t samples
);

    localparam int msb = rp_pkg::code_width - 1;

    rp_pkg::adc_code_t code_a_q;
    rp_pkg::adc_code_t code_b_q;
    logic              valid_q;

    // Pad registers, taken every cycle
    always_ff @(posedge adc_clk_125) begin
        code_a_q <= adc.ch_a;
        code_b_q <= adc.ch_b;
    end

    // First sample after reset is already valid
    always_ff @(posedge adc_clk_125) begin
        if (adc_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
        end
    end

    // Offset binary to two's complement by inverting the MSB
    always_comb begin
        samples.valid = valid_q;
        samples.ch_a  = rp_pkg::sample_t'({~code_a_q[msb], code_a_q[msb-1:0]});
        samples.ch_b  = rp_pkg::sample_t'({~code_b_q[msb], code_b_q[msb-1:0]});
    end

endmodule

//--- hw/gain_offset.sv
`timescale 1ns/1ps

module gain_offset (
    input  logic                 adc_clk_125,
    input  logic                 adc_rst,
    input  rp_pkg::path_cfg_t    cfg,
    input  rp_pkg::sample_pair_t in_samples,
    output rp_pkg::sample_pair_t out_samples
);

    rp_pkg::sample_t   in_s   [2];
    rp_pkg::chan_cfg_t ch_cfg [2];
    rp_pkg::prod_t     prod_q [2];   // Stage one
    rp_pkg::sum_t      sum_c  [2];
    rp_pkg::sample_t   sat_c  [2];
    rp_pkg::sample_t   res_q  [2];   // Stage two
    logic              valid_s1;
    logic              valid_s2;

    // Index 0 is channel A, 1 is channel B
    assign in_s[0]   = in_samples.ch_a;
    assign in_s[1]   = in_samples.ch_b;
    assign ch_cfg[0] = cfg.cfg_a;
    assign ch_cfg[1] = cfg.cfg_b;

    always_ff @(posedge adc_clk_125) begin
        for (int i = 0; i < 2; i++) begin
            prod_q[i] <= rp_pkg::prod_t'(in_s[i]) * rp_pkg::prod_t'(ch_cfg[i].gain);
        end
    end

    // Arithmetic shift floors, then offset and clamp
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            sum_c[i] = rp_pkg::sum_t'(prod_q[i] >>> rp_pkg::frac_bits)
                     + rp_pkg::sum_t'(ch_cfg[i].offset);
            if (sum_c[i] > rp_pkg::sum_t'(rp_pkg::sample_max)) begin
                sat_c[i] = rp_pkg::sample_max;
            end else if (sum_c[i] < rp_pkg::sum_t'(rp_pkg::sample_min)) begin
                sat_c[i] = rp_pkg::sample_min;
            end else begin
                sat_c[i] = rp_pkg::sample_t'(sum_c[i]);
            end
        end
    end

    always_ff @(posedge adc_clk_125) begin
        for (int i = 0; i < 2; i++) begin
            res_q[i] <= sat_c[i];
        end
    end

    // Valid tracks the two register stages
    always_ff @(posedge adc_clk_125) begin
        if (adc_rst) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= in_samples.valid;
            valid_s2 <= valid_s1;
        end
    end

    always_comb begin
        out_samples.valid = valid_s2;
        out_samples.ch_a  = res_q[0];
        out_samples.ch_b  = res_q[1];
    end

endmodule

//--- hw/dac_formatter.sv
`timescale 1ns/1ps

module dac_formatter (
    input  logic                 adc_clk_125,
    input  logic                 adc_rst,
    input  rp_pkg::sample_pair_t samples,
    output rp_pkg::dac_pair_t    dac,
    output logic                 dac_valid
);

    localparam int msb = rp_pkg::sample_width - 1;

    rp_pkg::dac_code_t code_a;
    rp_pkg::dac_code_t code_b;
    rp_pkg::dac_pair_t dac_q;
    logic              valid_q;

    // Back to offset binary
    assign code_a = rp_pkg::dac_code_t'({~samples.ch_a[msb], samples.ch_a[msb-1:0]});
    assign code_b = rp_pkg::dac_code_t'({~samples.ch_b[msb], samples.ch_b[msb-1:0]});

    always_ff @(posedge adc_clk_125) begin
        if (adc_rst) begin
            dac_q.ch_a <= rp_pkg::dac_mid;   // Park at mid-scale
            dac_q.ch_b <= rp_pkg::dac_mid;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= samples.valid;
            if (samples.valid) begin
                dac_q.ch_a <= code_a;
                dac_q.ch_b <= code_b;
            end else begin
                // Pipeline still filling
                dac_q.ch_a <= rp_pkg::dac_mid;
                dac_q.ch_b <= rp_pkg::dac_mid;
            end
        end
    end

    assign dac       = dac_q;
    assign dac_valid = valid_q;

endmodule

//--- hw/rp_signal_path_top.sv
`timescale 1ns/1ps

module rp_signal_path_top (
    input  logic              adc_clk_in,
    input  logic              rst_n,
    input  rp_pkg::adc_pair_t adc,
    input  rp_pkg::path_cfg_t cfg,

    output rp_pkg::dac_pair_t dac,
    output logic              dac_valid,
    output logic              usr_clk,
    output logic              dac_clk_250,
    output logic              dac_clk_250_315,
    output logic              usr_rst,
    output logic              dac_rst
);

    logic                 adc_clk_125;
    logic                 adc_rst;
    rp_pkg::sample_pair_t adc_samples;    // Capture to gain stage
    rp_pkg::sample_pair_t scaled_samples; // Gain stage to DAC formatter

    red_pitaya_infrastructure infra_inst (
        .adc_clk_in      (adc_clk_in),
        .rst_n           (rst_n),
        .usr_clk         (usr_clk),
        .usr_rst         (usr_rst),
        .adc_clk_125     (adc_clk_125),
        .adc_rst         (adc_rst),
        .dac_clk_250     (dac_clk_250),
        .dac_rst         (dac_rst),
        .dac_clk_250_315 (dac_clk_250_315)
    );

    adc_capture adc_capture_inst (
        .adc_clk_125 (adc_clk_125),
        .adc_rst     (adc_rst),
        .adc         (adc),
        .samples     (adc_samples)
    );

    gain_offset gain_offset_inst (
        .adc_clk_125 (adc_clk_125),
        .adc_rst     (adc_rst),
        .cfg         (cfg),
        .in_samples  (adc_samples),
        .out_samples (scaled_samples)
    );

    dac_formatter dac_formatter_inst (
        .adc_clk_125 (adc_clk_125),
        .adc_rst     (adc_rst),
        .samples     (scaled_samples),
        .dac         (dac),
        .dac_valid   (dac_valid)
    );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free-running clock, first rising edge at half a period
    always begin
        #(period_ns / 2.0);
        clk = ~clk;
    end

endmodule

//--- tests/tb_rp_signal_path.sv
`timescale 1ns/1ps

module tb_rp_signal_path;

    localparam int max_cycles  = 2000;   // Tests need about 1300 cycles
    localparam int rst_cycles  = 10;
    localparam int path_delay  = 4;      // Edges from adc input to dac output
    localparam int release_max = rp_pkg::lock_delay + rp_pkg::rst_sync_stages + 2;

    logic              clk;
    logic              rst_n;
    rp_pkg::adc_pair_t adc;
    rp_pkg::path_cfg_t cfg;
    rp_pkg::dac_pair_t dac;
    logic              dac_valid;
    logic              usr_clk;
    logic              dac_clk_250;
    logic              dac_clk_250_315;
    logic              usr_rst;
    logic              dac_rst;

    rp_pkg::adc_pair_t sent_q[$];   // Driven words with the oldest first
    string             test_name;
    logic              unity_mode;
    logic              valid_expected;   // dac_valid must stay high while set
    int                cycle_cnt;
    int                dac_checks;
    int                flag_checks;
    int                dac_errors;
    int                flag_errors;
    int                other_errors;

    tb_clk_gen #(.period_ns(100.0)) clk_gen_inst (.clk(clk));

    rp_signal_path_top DUT (
        .adc_clk_in      (clk),
        .rst_n           (rst_n),
        .adc             (adc),
        .cfg             (cfg),
        .dac             (dac),
        .dac_valid       (dac_valid),
        .usr_clk         (usr_clk),
        .dac_clk_250     (dac_clk_250),
        .dac_clk_250_315 (dac_clk_250_315),
        .usr_rst         (usr_rst),
        .dac_rst         (dac_rst)
    );

    // Expected DAC code for one raw ADC code through one channel
    function automatic rp_pkg::dac_code_t ref_code(input rp_pkg::adc_code_t raw,
                                                   input rp_pkg::chan_cfg_t c);
        int s;
        int p;
        int y;
        s = int'(raw) - 8192;                          // Offset binary to signed
        p = s * int'($signed(c.gain));
        y = (p >>> rp_pkg::frac_bits) + int'($signed(c.offset));   // Floor shift
        if (y > 8191) begin
            y = 8191;
        end else if (y < -8192) begin
            y = -8192;
        end
        return rp_pkg::dac_code_t'(y + 8192);
    endfunction

    function automatic rp_pkg::dac_pair_t expect_pair(input rp_pkg::adc_pair_t a,
                                                      input rp_pkg::path_cfg_t c);
        rp_pkg::dac_pair_t e;
        e.ch_a = ref_code(a.ch_a, c.cfg_a);
        e.ch_b = ref_code(a.ch_b, c.cfg_b);
        return e;
    endfunction

    function automatic rp_pkg::path_cfg_t make_cfg(input int gain_a, input int offset_a,
                                                   input int gain_b, input int offset_b);
        rp_pkg::path_cfg_t c;
        c.cfg_a.gain   = rp_pkg::gain_t'(gain_a);
        c.cfg_a.offset = rp_pkg::sample_t'(offset_a);
        c.cfg_b.gain   = rp_pkg::gain_t'(gain_b);
        c.cfg_b.offset = rp_pkg::sample_t'(offset_b);
        return c;
    endfunction

    function automatic rp_pkg::adc_pair_t rand_pair();
        rp_pkg::adc_pair_t p;
        p.ch_a = rp_pkg::adc_code_t'($urandom);
        p.ch_b = rp_pkg::adc_code_t'($urandom);
        return p;
    endfunction

    task automatic check_dac(input string what, input rp_pkg::dac_pair_t exp,
                             input rp_pkg::dac_pair_t act);
        dac_checks++;
        if (act !== exp) begin
            dac_errors++;
            $display("[FAIL] %s %s: expected %0d/%0d actual %0d/%0d", test_name, what,
                     exp.ch_a, exp.ch_b, act.ch_a, act.ch_b);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        flag_checks++;
        if (act !== exp) begin
            flag_errors++;
            $display("[FAIL] %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    // One word per cycle driven 1 ns after the rising edge
    task automatic drive_word(input rp_pkg::adc_pair_t w);
        @(posedge clk);
        #1;
        adc = w;
        sent_q.push_back(w);
    endtask

    task automatic run_random(input int n);
        repeat (n) drive_word(rand_pair());
    endtask

    task automatic run_extremes(input int n);
        rp_pkg::adc_pair_t w;
        repeat (n) begin
            w.ch_a = ($urandom % 2) ? 14'd16383 : 14'd0;
            w.ch_b = ($urandom % 2) ? 14'd16383 : 14'd0;
            drive_word(w);
        end
    endtask

    // Holds rst_n low and loads new_cfg once the path is quiet
    task automatic hold_reset(input rp_pkg::path_cfg_t new_cfg);
        rst_n = 1'b0;
        valid_expected = 1'b0;
        for (int i = 1; i <= rst_cycles; i++) begin
            drive_word(rand_pair());
            if (i >= rp_pkg::rst_sync_stages + 1) begin
                check_flag("dac_valid in reset", 1'b0, dac_valid);
                check_flag("usr_rst in reset", 1'b1, usr_rst);
                check_flag("dac_rst in reset", 1'b1, dac_rst);
                check_dac("dac in reset", {rp_pkg::dac_mid, rp_pkg::dac_mid}, dac);
            end
            if (i == rp_pkg::rst_sync_stages + 1) begin
                cfg = new_cfg;
            end
        end
        rst_n = 1'b1;
    endtask

    task automatic release_reset();
        rp_pkg::adc_pair_t w;
        rp_pkg::adc_pair_t first_w;
        int                n;
        n = 0;
        first_w = '0;
        while (n < release_max && (usr_rst !== 1'b0 || dac_rst !== 1'b0)) begin
            w = rand_pair();
            drive_word(w);
            first_w = w;   // Driven on the edge where the resets fell
            n++;
        end
        check_flag("usr_rst after release", 1'b0, usr_rst);
        check_flag("dac_rst after release", 1'b0, dac_rst);
        if (usr_rst !== 1'b0 || dac_rst !== 1'b0) begin
            other_errors++;
            $display("Error in %s: domain resets still high %0d cycles after rst_n release",
                     test_name, n);
        end
        // adc_rst shares usr_rst's clock and lock in this build
        n = 0;
        while (n < path_delay + 4 && dac_valid !== 1'b1) begin
            drive_word(rand_pair());
            n++;
        end
        check_flag("dac_valid after release", 1'b1, dac_valid);
        if (n != path_delay) begin
            other_errors++;
            $display("Error in %s: dac_valid rose %0d cycles after adc_rst fell, not %0d",
                     test_name, n, path_delay);
        end
        check_dac("first valid word", expect_pair(first_w, cfg), dac);
        valid_expected = 1'b1;
    endtask

    task automatic print_counts();
        $display("Checked %0d dac words and %0d flags: %0d dac errors, %0d flag errors, %0d other",
                 dac_checks, flag_checks, dac_errors, flag_errors, other_errors);
    endtask

    // Pass-through build exports the input clock on every clock output
    always @(clk) begin : clock_follow
        #1;
        check_flag("usr_clk", clk, usr_clk);
        check_flag("dac_clk_250", clk, dac_clk_250);
        check_flag("dac_clk_250_315", clk, dac_clk_250_315);
    end

    // Scoreboard samples on the falling edge where outputs are settled
    always @(negedge clk) begin : scoreboard
        rp_pkg::dac_pair_t exp;
        rp_pkg::adc_pair_t old;
        if (valid_expected) begin
            check_flag("dac_valid held", 1'b1, dac_valid);
        end
        if (sent_q.size() == path_delay + 1) begin
            old = sent_q.pop_front();
            if (dac_valid === 1'b1) begin
                if (unity_mode) begin
                    exp = rp_pkg::dac_pair_t'(old);   // Unity path returns the code
                end else begin
                    exp = expect_pair(old, cfg);
                end
                check_dac("scoreboard", exp, dac);
            end
        end
        if (dac_valid === 1'b0) begin
            check_dac("idle level", {rp_pkg::dac_mid, rp_pkg::dac_mid}, dac);
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        print_counts();
        $display("TEST FAIL");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(13));
        rst_n          = 1'b0;
        adc            = '0;
        cfg            = make_cfg(8192, 0, 8192, 0);
        unity_mode     = 1'b1;
        valid_expected = 1'b0;
        dac_checks     = 0;
        flag_checks    = 0;
        dac_errors     = 0;
        flag_errors    = 0;
        other_errors   = 0;

        test_name = "reset_release";
        hold_reset(make_cfg(8192, 0, 8192, 0));
        release_reset();

        test_name = "unity";
        run_random(300);

        test_name = "gain_offset";
        unity_mode = 1'b0;
        hold_reset(make_cfg(4096, 100, -8192, -50));
        release_reset();
        run_random(300);

        test_name = "saturation";
        hold_reset(make_cfg(24576, 8000, 24576, -8000));
        release_reset();
        run_extremes(100);

        test_name = "re_reset";
        hold_reset(make_cfg(4096, 100, -8192, -50));
        release_reset();
        run_random(200);
        hold_reset(cfg);                                   // Mid-stream with the same settings
        release_reset();
        run_random(200);

        repeat (2) drive_word(rand_pair());
        print_counts();
        if (dac_errors + flag_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- rp_signal_path.f
hw/rp_pkg.sv
hw/red_pitaya_infrastructure.sv
hw/adc_capture.sv
hw/gain_offset.sv
hw/dac_formatter.sv
hw/rp_signal_path_top.sv
tests/tb_clk_gen.sv
tests/tb_rp_signal_path.sv
